// ==== logic/multiPortRam_settings.svh ====
// ##########################################################
// Multi-port RAM sizing
// Entry count, entry width and port counts of the
// live-value-table RAM
// ##########################################################

`ifndef MULTI_PORT_RAM_SETTINGS_SVH
`define MULTI_PORT_RAM_SETTINGS_SVH

// Addressable entries, must be a power of two
`define RAM_ENTRY_NUM 32

// Bits per entry
`define RAM_DATA_WIDTH 16

// Write ports, each one owns a set of banks
`define RAM_WRITE_PORTS 2

// Read ports, one bank copy per read port in every set
`define RAM_READ_PORTS 3

`endif

// ==== logic/multiPortRamPkg.sv ====
// ##########################################################
// Multi-port RAM types
// Address, data, live-value selector and write request
// ##########################################################

`include "multiPortRam_settings.svh"

package multiPortRamPkg;

    localparam int addrWidth = $clog2(`RAM_ENTRY_NUM);
    localparam int dataWidth = `RAM_DATA_WIDTH;

    // Keep the selector at least one bit wide for a single write port
    localparam int portSelWidth =
        (`RAM_WRITE_PORTS > 1) ? $clog2(`RAM_WRITE_PORTS) : 1;

    // Entry index
    typedef logic [addrWidth-1:0] RamAddr;

    // Entry value
    typedef logic [dataWidth-1:0] RamData;

    // Index of the write port that last wrote an entry
    typedef logic [portSelWidth-1:0] PortSel;

    // One write port's request for a single cycle
    typedef struct packed {
        logic   enable;
        RamAddr addr;
        RamData data;
    } WriteReq;

endpackage

// ==== logic/distributedBank.sv ====
// ##########################################################
// Distributed RAM bank
// One write port on the clock edge, one combinational read
// ##########################################################

`include "multiPortRam_settings.svh"

module distributedBank (
    input  logic                     clk,
    input  multiPortRamPkg::WriteReq writeReq,
    input  multiPortRamPkg::RamAddr  readAddr,
    output multiPortRamPkg::RamData  readData
);

    // Storage, intended to map onto LUT RAM
    multiPortRamPkg::RamData memArray [`RAM_ENTRY_NUM];

    // Write on the edge when the request is enabled
    always_ff @(posedge clk) begin
        if (writeReq.enable) begin
            memArray[writeReq.addr] <= writeReq.data;
        end
    end

    // Asynchronous read
    // A write in the current cycle shows only after the edge
    assign readData = memArray[readAddr];

endmodule

// ==== logic/liveValueTable.sv ====
// ##########################################################
// Live value table
// Tracks which write port last wrote each entry and looks
// up that port for every read address
// ##########################################################

`include "multiPortRam_settings.svh"

module liveValueTable (
    input  logic                     clk,
    input  logic                     arstN,
    input  multiPortRamPkg::WriteReq writeReq [`RAM_WRITE_PORTS],
    input  multiPortRamPkg::RamAddr  readAddr [`RAM_READ_PORTS],
    output multiPortRamPkg::PortSel  liveSel  [`RAM_READ_PORTS]
);

    // One selector per entry, kept in flip-flops
    multiPortRamPkg::PortSel liveTable [`RAM_ENTRY_NUM];

    // Record the writing port's own index
    // Same-address writes from two ports are excluded by the caller
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int e = 0; e < `RAM_ENTRY_NUM; e++) begin
                liveTable[e] <= '0;
            end
        end else begin
            for (int w = 0; w < `RAM_WRITE_PORTS; w++) begin
                if (writeReq[w].enable) begin
                    liveTable[writeReq[w].addr] <= multiPortRamPkg::PortSel'(w);
                end
            end
        end
    end

    // Combinational lookup, one per read port
    always_comb begin
        for (int r = 0; r < `RAM_READ_PORTS; r++) begin
            liveSel[r] = liveTable[readAddr[r]];
        end
    end

    // Two ports on one entry in one cycle would leave the table
    // and the bank sets disagreeing about the live copy
    for (genvar i = 0; i < `RAM_WRITE_PORTS; i++) begin : conflictOuter
        for (genvar j = i + 1; j < `RAM_WRITE_PORTS; j++) begin : conflictInner
            writeConflict: assert property (
                @(posedge clk) disable iff (!arstN)
                !(writeReq[i].enable && writeReq[j].enable &&
                  writeReq[i].addr == writeReq[j].addr)
            ) else begin
                $error("Write ports %0d and %0d hit entry %0h in one cycle",
                       i, j, writeReq[i].addr);
            end
        end
    end

endmodule

// ==== logic/replicatedBankArray.sv ====
// ##########################################################
// Replicated bank array
// One bank set per write port, one copy per read port, and
// a per-read-port choice of the live set
// ##########################################################

`include "multiPortRam_settings.svh"

module replicatedBankArray (
    input  logic                     clk,
    input  multiPortRamPkg::WriteReq writeReq [`RAM_WRITE_PORTS],
    input  multiPortRamPkg::RamAddr  readAddr [`RAM_READ_PORTS],
    input  multiPortRamPkg::PortSel  liveSel  [`RAM_READ_PORTS],
    output multiPortRamPkg::RamData  readData [`RAM_READ_PORTS]
);

    // Output of every bank, by write set and read copy
    multiPortRamPkg::RamData bankData [`RAM_WRITE_PORTS][`RAM_READ_PORTS];

    // All copies in a set see the same write stream
    // Each copy serves exactly one read port
    for (genvar w = 0; w < `RAM_WRITE_PORTS; w++) begin : writeSet
        for (genvar r = 0; r < `RAM_READ_PORTS; r++) begin : readCopy
            distributedBank bank_i (
                .clk      (clk),
                .writeReq (writeReq[w]),
                .readAddr (readAddr[r]),
                .readData (bankData[w][r])
            );
        end
    end

    // Forward the copy held by the set that wrote the entry last
    for (genvar r = 0; r < `RAM_READ_PORTS; r++) begin : readMux
        assign readData[r] = bankData[liveSel[r]][r];
    end

endmodule

// ==== logic/lvtMultiPortRam.sv ====
// ##########################################################
// LVT multi-port RAM
// N-read / M-write RAM from distributed banks and a live
// value table, with combinational reads
// ##########################################################

`include "multiPortRam_settings.svh"

module lvtMultiPortRam (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    writeEn   [`RAM_WRITE_PORTS],
    input  multiPortRamPkg::RamAddr writeAddr [`RAM_WRITE_PORTS],
    input  multiPortRamPkg::RamData writeData [`RAM_WRITE_PORTS],
    input  multiPortRamPkg::RamAddr readAddr  [`RAM_READ_PORTS],
    output multiPortRamPkg::RamData readData  [`RAM_READ_PORTS]
);

    multiPortRamPkg::WriteReq writeReq [`RAM_WRITE_PORTS];
    multiPortRamPkg::PortSel  liveSel  [`RAM_READ_PORTS];

    // Bundle each write port into one request
    for (genvar w = 0; w < `RAM_WRITE_PORTS; w++) begin : packReq
        assign writeReq[w] = multiPortRamPkg::WriteReq'{
            enable: writeEn[w],
            addr:   writeAddr[w],
            data:   writeData[w]
        };
    end

    liveValueTable liveValueTable_i (
        .clk      (clk),
        .arstN    (arstN),
        .writeReq (writeReq),
        .readAddr (readAddr),
        .liveSel  (liveSel)
    );

    replicatedBankArray replicatedBankArray_i (
        .clk      (clk),
        .writeReq (writeReq),
        .readAddr (readAddr),
        .liveSel  (liveSel),
        .readData (readData)
    );

    // End to end: a write is visible one cycle later on any read port
    // that names the same entry, through both the table and the banks
    for (genvar w = 0; w < `RAM_WRITE_PORTS; w++) begin : chkWrite
        for (genvar r = 0; r < `RAM_READ_PORTS; r++) begin : chkRead
            writeThenRead: assert property (
                @(posedge clk) disable iff (!arstN)
                (writeReq[w].enable ##1 readAddr[r] == $past(writeReq[w].addr))
                |-> readData[r] == $past(writeReq[w].data)
            ) else begin
                $error("Read port %0d lost the write of port %0d", r, w);
            end
        end
    end

endmodule

// ==== testbench/clockGen.sv ====
// ##########################################################
// Testbench clock and reset
// 20-unit clock, reset held low for the first 8 cycles
// ##########################################################

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Release on a falling edge, clear of the write edge
    initial begin
        arstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== testbench/lvtMultiPortRamTb.sv ====
// ##########################################################
// Testbench for the LVT multi-port RAM
// Directed and fixed-seed random traffic, checked against
// a reference model of the memory contents
// ##########################################################

`include "multiPortRam_settings.svh"

module lvtMultiPortRamTb;

    localparam int writePorts = `RAM_WRITE_PORTS;
    localparam int readPorts = `RAM_READ_PORTS;
    localparam int entryNum = `RAM_ENTRY_NUM;
    localparam int randomCycles = 2000;
    // Reset, directed section and random section, with margin
    localparam int cycleLimit = 2500;

    logic                    clk;
    logic                    arstN;
    logic                    writeEn   [writePorts];
    multiPortRamPkg::RamAddr writeAddr [writePorts];
    multiPortRamPkg::RamData writeData [writePorts];
    multiPortRamPkg::RamAddr readAddr  [readPorts];
    multiPortRamPkg::RamData readData  [readPorts];

    // Reference model, one value and one written flag per entry
    multiPortRamPkg::RamData modelMem     [entryNum];
    logic                    modelWritten [entryNum];

    int cycleCount = 0;

    clockGen clockGen_i (
        .clk   (clk),
        .arstN (arstN)
    );

    lvtMultiPortRam lvtMultiPortRam_i (
        .clk       (clk),
        .arstN     (arstN),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .readAddr  (readAddr),
        .readData  (readData)
    );

    // Model takes every enabled write on the rising edge
    always @(posedge clk) begin
        if (arstN) begin
            for (int w = 0; w < writePorts; w++) begin
                if (writeEn[w]) begin
                    modelMem[writeAddr[w]] = writeData[w];
                    modelWritten[writeAddr[w]] = 1'b1;
                end
            end
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic checkEqual(input string name, input multiPortRamPkg::RamData expected,
                              input multiPortRamPkg::RamData actual);
        assert (actual === expected) else begin
            $display("[ERROR] time %0t %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Read data mismatch");
        end
    endtask

    // Compare every read port whose entry holds a known value
    task automatic checkReads();
        for (int r = 0; r < readPorts; r++) begin
            if (modelWritten[readAddr[r]]) begin
                checkEqual($sformatf("readData[%0d]", r), modelMem[readAddr[r]], readData[r]);
            end
        end
    endtask

    // Directed expectation on all read ports
    task automatic expectAll(input multiPortRamPkg::RamData expected);
        for (int r = 0; r < readPorts; r++) begin
            checkEqual($sformatf("readData[%0d]", r), expected, readData[r]);
        end
    endtask

    // Move to the next falling edge and check the settled reads
    task automatic advanceCycle();
        @(negedge clk);
        checkReads();
    endtask

    task automatic clearWrites();
        for (int w = 0; w < writePorts; w++) begin
            writeEn[w] = 1'b0;
        end
    endtask

    task automatic driveWrite(input int port, input multiPortRamPkg::RamAddr addr,
                              input multiPortRamPkg::RamData data);
        writeEn[port] = 1'b1;
        writeAddr[port] = addr;
        writeData[port] = data;
    endtask

    task automatic readAll(input multiPortRamPkg::RamAddr addr);
        for (int r = 0; r < readPorts; r++) begin
            readAddr[r] = addr;
        end
    endtask

    // Random enables and data, write addresses kept distinct
    task automatic randomCycle();
        logic clash;
        for (int w = 0; w < writePorts; w++) begin
            writeEn[w] = ($urandom_range(0, 1) == 1);
            writeData[w] = multiPortRamPkg::RamData'($urandom);
            do begin
                writeAddr[w] = multiPortRamPkg::RamAddr'($urandom);
                clash = 1'b0;
                for (int p = 0; p < w; p++) begin
                    if (writeAddr[p] == writeAddr[w]) begin
                        clash = 1'b1;
                    end
                end
            end while (clash);
        end
        for (int r = 0; r < readPorts; r++) begin
            readAddr[r] = multiPortRamPkg::RamAddr'($urandom);
        end
    endtask

    initial begin
        void'($urandom(32'h91a8_0635));
        for (int e = 0; e < entryNum; e++) begin
            modelMem[e] = '0;
            modelWritten[e] = 1'b0;
        end
        for (int w = 0; w < writePorts; w++) begin
            writeEn[w] = 1'b0;
            writeAddr[w] = '0;
            writeData[w] = '0;
        end
        readAll('0);

        @(posedge arstN);
        @(negedge clk);

        // Single write on port 0, seen on every read port
        driveWrite(0, 5'h03, 16'h1234);
        readAll(5'h03);
        advanceCycle();
        expectAll(16'h1234);
        clearWrites();
        advanceCycle();

        // Both write ports at once on different entries
        driveWrite(0, 5'h0a, 16'haaaa);
        driveWrite(1, 5'h15, 16'h5555);
        advanceCycle();
        clearWrites();
        readAddr[0] = 5'h0a;
        readAddr[1] = 5'h15;
        readAddr[2] = 5'h0a;
        advanceCycle();
        checkEqual("readData[0]", 16'haaaa, readData[0]);
        checkEqual("readData[1]", 16'h5555, readData[1]);
        checkEqual("readData[2]", 16'haaaa, readData[2]);
        readAddr[0] = 5'h15;
        readAddr[1] = 5'h0a;
        readAddr[2] = 5'h15;
        advanceCycle();
        checkEqual("readData[0]", 16'h5555, readData[0]);
        checkEqual("readData[1]", 16'haaaa, readData[1]);
        checkEqual("readData[2]", 16'h5555, readData[2]);

        // Last writer wins, port 0 then port 1 then port 0 again
        driveWrite(0, 5'h07, 16'h0700);
        readAll(5'h07);
        advanceCycle();
        expectAll(16'h0700);
        clearWrites();
        driveWrite(1, 5'h07, 16'h1700);
        advanceCycle();
        expectAll(16'h1700);
        clearWrites();
        advanceCycle();
        expectAll(16'h1700);
        driveWrite(0, 5'h07, 16'h0777);
        advanceCycle();
        expectAll(16'h0777);
        clearWrites();
        advanceCycle();

        // Read during the write cycle shows the old value
        driveWrite(1, 5'h07, 16'hbeef);
        readAll(5'h07);
        #1;
        expectAll(16'h0777);
        advanceCycle();
        expectAll(16'hbeef);
        clearWrites();
        advanceCycle();

        // Random traffic on all ports
        for (int c = 0; c < randomCycles; c++) begin
            randomCycle();
            advanceCycle();
        end
        clearWrites();
        advanceCycle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/multiPortRamPkg.sv
logic/distributedBank.sv
logic/liveValueTable.sv
logic/replicatedBankArray.sv
logic/lvtMultiPortRam.sv
testbench/clockGen.sv
testbench/lvtMultiPortRamTb.sv

// ==== Bender.yml ====
package:
  name: lvt_multi_port_ram

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/multiPortRamPkg.sv
      - logic/distributedBank.sv
      - logic/liveValueTable.sv
      - logic/replicatedBankArray.sv
      - logic/lvtMultiPortRam.sv

  - target: test
    include_dirs:
      - logic
    files:
      - testbench/clockGen.sv
      - testbench/lvtMultiPortRamTb.sv
